// ==== hdl/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// core widths
`define WORD_W        64   // data and address
`define INSTR_W       32
`define REG_IDX_W     5    // 32 integer registers

// instruction cache geometry
`define LINE_W        512  // 8 bus beats, 16 instructions
`define ICACHE_LINES  16   // direct mapped sets

// system bus
`define BUS_DATA_W    64
`define BUS_TAG_W     13

`endif

// ==== hdl/rv_pkg.sv ====
`include "rv_params.svh"

package rv_pkg;

  // one instruction word seen as R, I or U format
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [`REG_IDX_W-1:0] rs2;
      logic [`REG_IDX_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [`REG_IDX_W-1:0] rd;
      logic [6:0]            opcode;
    } r_fmt;
    struct packed {
      logic [11:0]           imm12;
      logic [`REG_IDX_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [`REG_IDX_W-1:0] rd;
      logic [6:0]            opcode;
    } i_fmt;
    struct packed {
      logic [19:0]           imm20;
      logic [`REG_IDX_W-1:0] rd;
      logic [6:0]            opcode;
    } u_fmt;
  } instr_u;

  // major opcodes handled by this core
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // reg-reg
    OP_IMM = 7'b0010011,  // reg-imm
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    SYSTEM = 7'b1110011   // ecall
  } opcode_e;

  typedef enum logic [2:0] {
    F3_ADD, F3_SLL, F3_SLT, F3_SLTU, F3_XOR, F3_SR, F3_OR, F3_AND
  } funct3_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B, ECALL
  } alu_op_e;

endpackage

// ==== hdl/bus_fetch.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module bus_fetch (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fill_req,
  input  logic [`WORD_W-1:0]     fill_addr,
  output logic [`LINE_W-1:0]     fill_line,
  output logic                   fill_done,
  output logic                   bus_reqcyc,
  input  logic                   bus_reqack,
  output logic [`BUS_DATA_W-1:0] bus_req,
  output logic [`BUS_TAG_W-1:0]  bus_reqtag,
  input  logic                   bus_respcyc,
  output logic                   bus_respack,
  input  logic [`BUS_DATA_W-1:0] bus_resp,
  input  logic [`BUS_TAG_W-1:0]  bus_resptag
);

  localparam int BEATS = `LINE_W / `BUS_DATA_W;  // 8 beats per line
  localparam int CNT_W = $clog2(BEATS);
  localparam int OFF_W = $clog2(`LINE_W / 8);    // byte offset inside a line
  // read request to the memory target
  localparam logic [`BUS_TAG_W-1:0] READ_TAG = {1'b1, 4'b0001, 8'h00};

  typedef enum logic [1:0] {IDLE, REQUEST, COLLECT, DONE} state_e;

  state_e             state;
  logic [CNT_W-1:0]   beat_cnt;
  logic [`LINE_W-1:0] line_buf;
  logic               beat_ok;

  assign bus_reqcyc  = (state == REQUEST);  // held until reqack
  assign bus_reqtag  = READ_TAG;
  assign beat_ok     = bus_respcyc && (bus_resptag == READ_TAG);  // beat answering our read
  assign bus_respack = (state == COLLECT) && beat_ok;
  assign fill_done   = (state == DONE);     // one cycle, line complete
  assign fill_line   = line_buf;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (fill_req) begin
            state    <= REQUEST;
            beat_cnt <= '0;
          end
        end
        REQUEST: if (bus_reqack) state <= COLLECT;  // request taken on this edge
        COLLECT: begin
          if (beat_ok) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == CNT_W'(BEATS - 1)) state <= DONE;  // eighth beat
          end
        end
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // address latch and line shift register
  always_ff @(posedge clk) begin
    if (state == IDLE && fill_req)
      bus_req <= {fill_addr[`WORD_W-1:OFF_W], OFF_W'(0)};  // line aligned
    // lowest address arrives first and ends in the low bits
    if (bus_respack)
      line_buf <= {bus_resp, line_buf[`LINE_W-1:`BUS_DATA_W]};
  end

endmodule

// ==== hdl/icache.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module icache (
  input  logic               clk,
  input  logic               reset,
  input  logic               fetch_go,
  input  logic [`WORD_W-1:0] pc,
  output rv_pkg::instr_u     instr,
  output logic               instr_valid,
  output logic               fill_req,
  output logic [`WORD_W-1:0] fill_addr,
  input  logic [`LINE_W-1:0] fill_line,
  input  logic               fill_done
);

  localparam int OFF_W  = $clog2(`LINE_W / 8);        // 6 byte offset bits
  localparam int IDX_W  = $clog2(`ICACHE_LINES);      // 4 set bits
  localparam int TAG_W  = `WORD_W - IDX_W - OFF_W;
  localparam int WSEL_W = $clog2(`LINE_W / `INSTR_W); // instruction slot

  logic [`LINE_W-1:0]       data_mem [`ICACHE_LINES];
  logic [TAG_W-1:0]         tag_mem  [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] valid;

  logic [TAG_W-1:0]    pc_tag;
  logic [IDX_W-1:0]    pc_idx;
  logic [WSEL_W-1:0]   pc_word;
  logic                hit;
  logic                fill_ret;   // line arriving for the pending miss
  logic [`INSTR_W-1:0] hit_word;
  logic [`INSTR_W-1:0] fill_word;

  // pc stays put while a fetch is outstanding, so it indexes the fill too
  assign pc_tag    = pc[`WORD_W-1 -: TAG_W];
  assign pc_idx    = pc[OFF_W +: IDX_W];
  assign pc_word   = pc[2 +: WSEL_W];
  assign hit       = valid[pc_idx] && (tag_mem[pc_idx] == pc_tag);
  assign fill_ret  = fill_done && fill_req;
  assign hit_word  = data_mem[pc_idx][pc_word * `INSTR_W +: `INSTR_W];
  assign fill_word = fill_line[pc_word * `INSTR_W +: `INSTR_W];  // bypass the new line

  always_ff @(posedge clk) begin
    if (reset) begin
      valid       <= '0;
      fill_req    <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= 1'b0;  // pulse
      if (fetch_go) begin
        if (hit) instr_valid <= 1'b1;
        else     fill_req    <= 1'b1;  // miss, hold until fill_done
      end
      if (fill_ret) begin
        fill_req       <= 1'b0;
        valid[pc_idx]  <= 1'b1;
        instr_valid    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_go && !hit)
      fill_addr <= {pc[`WORD_W-1:OFF_W], OFF_W'(0)};
    if (fill_ret) begin
      data_mem[pc_idx] <= fill_line;
      tag_mem[pc_idx]  <= pc_tag;
      instr            <= fill_word;
    end else if (fetch_go && hit) begin
      instr <= hit_word;
    end
  end

endmodule

// ==== hdl/reg_decode.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module reg_decode (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_pkg::instr_u        instr,
  input  logic [`WORD_W-1:0]    pc,
  input  logic                  instr_valid,
  input  logic                  wr_en,
  input  logic [`REG_IDX_W-1:0] wr_idx,
  input  logic [`WORD_W-1:0]    wr_data,
  output rv_pkg::alu_op_e       op,
  output logic [`REG_IDX_W-1:0] rd,
  output logic [`WORD_W-1:0]    a_val,
  output logic [`WORD_W-1:0]    b_val,
  output logic [`WORD_W-1:0]    a0_val,
  output logic [`WORD_W-1:0]    a7_val
);

  import rv_pkg::*;

  localparam int NREGS = 1 << `REG_IDX_W;

  logic [`WORD_W-1:0] regs [NREGS];
  opcode_e            opc;
  funct3_e            f3;
  logic [`WORD_W-1:0] rs1_val;
  logic [`WORD_W-1:0] rs2_val;
  logic [`WORD_W-1:0] imm_i;
  logic [`WORD_W-1:0] imm_u;
  logic               alt;  // instr bit 30, selects sub and sra

  // register file is all zero out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NREGS; i++) regs[i] <= '0;
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;  // x0 stays zero
    end
  end

  assign opc     = opcode_e'(instr.r_fmt.opcode);
  assign f3      = funct3_e'(instr.r_fmt.funct3);
  assign alt     = instr.r_fmt.funct7[5];
  assign rs1_val = regs[instr.r_fmt.rs1];
  assign rs2_val = regs[instr.r_fmt.rs2];
  assign a0_val  = regs[10];
  assign a7_val  = regs[17];

  // I immediate is sign extended from 12 bits
  assign imm_i = {{(`WORD_W - 12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
  // U immediate fills bits 31:12 and is sign extended to 64
  assign imm_u = {{(`WORD_W - 32){instr.u_fmt.imm20[19]}}, instr.u_fmt.imm20, 12'b0};

  always_comb begin
    op    = ADD;
    a_val = rs1_val;
    b_val = rs2_val;
    rd    = instr.r_fmt.rd;
    case (opc)
      OP, OP_IMM: begin
        if (opc == OP_IMM) b_val = imm_i;  // shamt sits in imm low bits
        case (f3)
          F3_ADD:  op = (opc == OP && alt) ? SUB : ADD;  // no subi
          F3_SLL:  op = SLL;
          F3_SLT:  op = SLT;
          F3_SLTU: op = SLTU;
          F3_XOR:  op = XOR;
          F3_SR:   op = alt ? SRA : SRL;
          F3_OR:   op = OR;
          F3_AND:  op = AND;
          default: op = ADD;
        endcase
      end
      LUI: begin
        a_val = '0;  // lui is 0 + imm
        b_val = imm_u;
      end
      AUIPC: begin
        a_val = pc;
        b_val = imm_u;
      end
      SYSTEM: begin
        // any system word other than ecall is a nop
        op = (instr.i_fmt.imm12 == '0 && f3 == F3_ADD) ? ECALL : PASS_B;
        rd = '0;
      end
      default: begin
        op = PASS_B;  // unknown opcode retires without a write
        rd = '0;
      end
    endcase
    if (!instr_valid) rd = '0;  // no destination unless the word is live
  end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module alu (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  rv_pkg::alu_op_e       op,
  input  logic [`REG_IDX_W-1:0] rd,
  input  logic [`WORD_W-1:0]    a_val,
  input  logic [`WORD_W-1:0]    b_val,
  input  logic [`WORD_W-1:0]    a0_val,
  input  logic [`WORD_W-1:0]    a7_val,
  output logic                  ex_valid,
  output logic [`REG_IDX_W-1:0] ex_rd,
  output logic [`WORD_W-1:0]    ex_data,
  output logic                  is_ecall,
  output logic [`WORD_W-1:0]    ex_a0,
  output logic [`WORD_W-1:0]    ex_a7
);

  import rv_pkg::*;

  logic [5:0]         shamt;   // rv64 shifts use 6 bits
  logic [`WORD_W-1:0] result;

  assign shamt = b_val[5:0];

  always_comb begin
    case (op)
      ADD:     result = a_val + b_val;  // also lui and auipc
      SUB:     result = a_val - b_val;
      SLL:     result = a_val << shamt;
      SLT:     result = {{(`WORD_W - 1){1'b0}}, $signed(a_val) < $signed(b_val)};
      SLTU:    result = {{(`WORD_W - 1){1'b0}}, a_val < b_val};
      XOR:     result = a_val ^ b_val;
      SRL:     result = a_val >> shamt;
      SRA:     result = $signed(a_val) >>> shamt;
      OR:      result = a_val | b_val;
      AND:     result = a_val & b_val;
      PASS_B:  result = b_val;
      default: result = '0;  // ecall has no result
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
      is_ecall <= 1'b0;
    end else begin
      ex_valid <= in_valid;
      is_ecall <= in_valid && (op == ECALL);
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      ex_rd   <= rd;
      ex_data <= result;
      ex_a0   <= a0_val;  // snapshot for the halt report
      ex_a7   <= a7_val;
    end
  end

endmodule

// ==== hdl/writeback.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module writeback (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ex_valid,
  input  logic [`REG_IDX_W-1:0] ex_rd,
  input  logic [`WORD_W-1:0]    ex_data,
  input  logic                  is_ecall,
  input  logic [`WORD_W-1:0]    ex_a0,
  input  logic [`WORD_W-1:0]    ex_a7,
  output logic                  wr_en,
  output logic [`REG_IDX_W-1:0] wr_idx,
  output logic [`WORD_W-1:0]    wr_data,
  output logic                  retire,
  output logic                  halted,
  output logic [`WORD_W-1:0]    exit_code,
  output logic [`WORD_W-1:0]    syscall_num
);

  // commit in the ex_valid cycle, x0 never written
  assign wr_en   = ex_valid && !is_ecall && (ex_rd != '0);
  assign wr_idx  = ex_rd;
  assign wr_data = ex_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      retire <= 1'b0;
      halted <= 1'b0;
    end else begin
      retire <= ex_valid && !is_ecall;             // ecall halts instead
      if (ex_valid && is_ecall) halted <= 1'b1;    // sticky
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid && is_ecall) begin
      exit_code   <= ex_a0;
      syscall_num <= ex_a7;
    end
  end

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module cpu_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`WORD_W-1:0]     entry,
  output logic                   halted,
  output logic [`WORD_W-1:0]     exit_code,
  output logic [`WORD_W-1:0]     syscall_num,
  output logic                   bus_reqcyc,
  input  logic                   bus_reqack,
  output logic [`BUS_DATA_W-1:0] bus_req,
  output logic [`BUS_TAG_W-1:0]  bus_reqtag,
  input  logic                   bus_respcyc,
  output logic                   bus_respack,
  input  logic [`BUS_DATA_W-1:0] bus_resp,
  input  logic [`BUS_TAG_W-1:0]  bus_resptag
);

  import rv_pkg::*;

  logic [`WORD_W-1:0]    pc;
  logic                  fetch_go, started, retire;
  instr_u                instr;
  logic                  instr_valid, fill_req, fill_done;
  logic [`WORD_W-1:0]    fill_addr;
  logic [`LINE_W-1:0]    fill_line;
  alu_op_e               op;
  logic [`REG_IDX_W-1:0] rd, ex_rd, wr_idx;
  logic [`WORD_W-1:0]    a_val, b_val, a0_val, a7_val;
  logic                  ex_valid, is_ecall, wr_en;
  logic [`WORD_W-1:0]    ex_data, ex_a0, ex_a7, wr_data;

  // one instruction in flight, the next fetch follows retire
  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= entry;
      started  <= 1'b0;
      fetch_go <= 1'b0;
    end else begin
      started  <= 1'b1;
      fetch_go <= !started || (retire && !halted);  // first fetch right after reset
      if (retire) pc <= pc + `WORD_W'(4);
    end
  end

  bus_fetch u_bus_fetch (.clk, .reset, .fill_req, .fill_addr, .fill_line, .fill_done,
                         .bus_reqcyc, .bus_reqack, .bus_req, .bus_reqtag,
                         .bus_respcyc, .bus_respack, .bus_resp, .bus_resptag);

  icache u_icache (.clk, .reset, .fetch_go, .pc, .instr, .instr_valid,
                   .fill_req, .fill_addr, .fill_line, .fill_done);

  reg_decode u_reg_decode (.clk, .reset, .instr, .pc, .instr_valid, .wr_en, .wr_idx,
                           .wr_data, .op, .rd, .a_val, .b_val, .a0_val, .a7_val);

  alu u_alu (.clk, .reset, .in_valid(instr_valid), .op, .rd, .a_val, .b_val, .a0_val,
             .a7_val, .ex_valid, .ex_rd, .ex_data, .is_ecall, .ex_a0, .ex_a7);

  writeback u_writeback (.clk, .reset, .ex_valid, .ex_rd, .ex_data, .is_ecall, .ex_a0,
                         .ex_a7, .wr_en, .wr_idx, .wr_data, .retire, .halted,
                         .exit_code, .syscall_num);

endmodule

// ==== testbench/sysbus_mem.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

// line memory on the system bus, random gaps before reqack and between beats
module sysbus_mem #(
  parameter logic [`WORD_W-1:0] BASE  = 64'h1000,
  parameter int                 WORDS = 64        // 64-bit words from BASE
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   bus_reqcyc,
  output logic                   bus_reqack,
  input  logic [`BUS_DATA_W-1:0] bus_req,
  input  logic [`BUS_TAG_W-1:0]  bus_reqtag,
  output logic                   bus_respcyc,
  input  logic                   bus_respack,
  output logic [`BUS_DATA_W-1:0] bus_resp,
  output logic [`BUS_TAG_W-1:0]  bus_resptag
);

  localparam int BEATS = `LINE_W / `BUS_DATA_W;

  typedef enum logic [2:0] {M_IDLE, M_GAP, M_ACK, M_BEAT_GAP, M_BEAT} mstate_e;

  logic [`BUS_DATA_W-1:0] mem [WORDS];
  mstate_e                state;
  int unsigned            gap;        // idle cycles still to insert
  int unsigned            beat;
  logic [`WORD_W-1:0]     line_addr;
  logic [`BUS_TAG_W-1:0]  tag;        // echoed on every beat

  // content of words never written, different at every address
  function automatic logic [63:0] fill_pattern(input logic [63:0] addr);
    return ~addr ^ {addr[40:0], addr[63:41]};
  endfunction

  function automatic logic [63:0] read_word(input logic [63:0] addr);
    logic [63:0] off;
    off = addr - BASE;
    if (addr >= BASE && (off >> 3) < WORDS)
      return mem[off >> 3];
    return fill_pattern(addr);
  endfunction

  // little endian, the lower instruction sits in bits 31:0
  task automatic store_instr(input logic [63:0] addr, input logic [31:0] word);
    logic [63:0] off;
    off = addr - BASE;
    if (addr[2])
      mem[off >> 3][63:32] = word;
    else
      mem[off >> 3][31:0] = word;
  endtask

  initial begin
    bus_reqack  = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp    = '0;
    bus_resptag = '0;
    for (int i = 0; i < WORDS; i++)
      mem[i] = fill_pattern(BASE + 64'(i) * 8);
  end

  // samples the bus on the edge, drives 1 ns later
  always @(posedge clk) begin
    if (reset) begin
      state       <= M_IDLE;
      bus_reqack  <= #1 1'b0;
      bus_respcyc <= #1 1'b0;
    end else begin
      case (state)
        M_IDLE: begin
          if (bus_reqcyc) begin
            gap   <= $urandom_range(0, 3);
            state <= M_GAP;
          end
        end
        M_GAP: begin
          if (gap == 0) begin
            bus_reqack <= #1 1'b1;
            line_addr  <= bus_req;
            tag        <= bus_reqtag;
            state      <= M_ACK;
          end else begin
            gap <= gap - 1;
          end
        end
        M_ACK: begin                          // master saw reqack on this edge
          bus_reqack <= #1 1'b0;
          beat       <= 0;
          gap        <= $urandom_range(0, 3);
          state      <= M_BEAT_GAP;
        end
        M_BEAT_GAP: begin
          if (gap == 0) begin
            bus_respcyc <= #1 1'b1;
            bus_resp    <= #1 read_word(line_addr + 64'(beat) * 8);  // lowest first
            bus_resptag <= #1 tag;
            state       <= M_BEAT;
          end else begin
            gap <= gap - 1;
          end
        end
        M_BEAT: begin
          if (bus_respack) begin              // beat taken
            bus_respcyc <= #1 1'b0;
            if (beat == BEATS - 1) begin
              state <= M_IDLE;
            end else begin
              beat  <= beat + 1;
              gap   <= $urandom_range(0, 3);
              state <= M_BEAT_GAP;
            end
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

endmodule

// ==== testbench/cpu_chk.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module cpu_chk (
  input logic                   clk,
  input logic                   reset,
  input logic                   bus_reqcyc,
  input logic                   bus_reqack,
  input logic [`BUS_DATA_W-1:0] bus_req,
  input logic [`BUS_TAG_W-1:0]  bus_reqtag,
  input logic                   bus_respcyc,
  input logic                   bus_respack,
  input logic                   halted,
  input logic                   fetch_go
);

  int unsigned fail_count = 0;  // read by the testbench top

  // bus and halt quiet through reset and the first cycle after it
  reset_quiet: assert property (@(posedge clk)
      reset |=> !bus_reqcyc && !bus_respack && !halted)
    else begin
      fail_count++;
      $error("bus or halt active during reset");
    end

  req_stable: assert property (@(posedge clk) disable iff (reset)
      bus_reqcyc && !bus_reqack |=> bus_reqcyc && $stable(bus_req) && $stable(bus_reqtag))
    else begin
      fail_count++;
      $error("bus request changed before reqack");
    end

  req_aligned: assert property (@(posedge clk) disable iff (reset)
      bus_reqcyc |-> bus_req[5:0] == 6'd0)   // 64-byte lines
    else begin
      fail_count++;
      $error("bus request address not line aligned");
    end

  resp_ack: assert property (@(posedge clk) disable iff (reset)
      bus_respack |-> bus_respcyc)
    else begin
      fail_count++;
      $error("respack raised without respcyc");
    end

  halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else begin
      fail_count++;
      $error("halted dropped without reset");
    end

  halt_no_req: assert property (@(posedge clk) disable iff (reset)
      halted |-> !$rose(bus_reqcyc) && !fetch_go)
    else begin
      fail_count++;
      $error("fetch or bus request after halt");
    end

endmodule

bind cpu_top cpu_chk chk_i (
  .clk, .reset, .bus_reqcyc, .bus_reqack, .bus_req, .bus_reqtag,
  .bus_respcyc, .bus_respack, .halted, .fetch_go
);

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module cpu_tb;

  localparam logic [`WORD_W-1:0] ENTRY = 64'h1000;
  localparam int TIMEOUT = 5000;  // cycles per wait loop
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;

  logic                   clk, reset, halted;
  logic [`WORD_W-1:0]     entry, exit_code, syscall_num;
  logic                   bus_reqcyc, bus_reqack, bus_respcyc, bus_respack;
  logic [`BUS_DATA_W-1:0] bus_req, bus_resp;
  logic [`BUS_TAG_W-1:0]  bus_reqtag, bus_resptag;

  logic [`INSTR_W-1:0] prog [$];
  logic [`WORD_W-1:0]  model [32];  // architectural registers of the reference
  int unsigned         req_count, tb_errors, cycles;

  cpu_top dut_i (.clk, .reset, .entry, .halted, .exit_code, .syscall_num,
                 .bus_reqcyc, .bus_reqack, .bus_req, .bus_reqtag,
                 .bus_respcyc, .bus_respack, .bus_resp, .bus_resptag);

  sysbus_mem #(.BASE(ENTRY), .WORDS(64)) mem_i (.clk, .reset, .bus_reqcyc, .bus_reqack,
      .bus_req, .bus_reqtag, .bus_respcyc, .bus_respack, .bus_resp, .bus_resptag);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset)
      req_count <= 0;
    else if (bus_reqcyc && bus_reqack)
      req_count <= req_count + 1;  // one per accepted line request
  end

  function automatic logic [63:0] upper_imm(input logic [19:0] imm20);
    return {{32{imm20[19]}}, imm20, 12'b0};  // bits 31:12 sign extended
  endfunction

  // rv64i arithmetic by funct3 where alt is instruction bit 30
  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[5:0];
      3'd2: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'd3: return (a < b) ? 64'd1 : 64'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt)
          return $signed(a) >>> b[5:0];
        return a >> b[5:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic set_reg(input int idx, input logic [63:0] val);
    if (idx != 0)
      model[idx] = val;  // x0 hardwired to zero
  endtask

  task automatic emit_alu(input logic is_imm, input logic [2:0] f3, input logic alt_in,
                          input int rd, input int rs1, input int rs2, input logic [11:0] imm_in);
    logic [11:0] imm;
    logic        alt;
    logic [63:0] b;
    imm = imm_in;
    alt = (f3 == 3'd5 || (f3 == 3'd0 && !is_imm)) ? alt_in : 1'b0;  // sub, sra, srai only
    if (is_imm && (f3 == 3'd1 || f3 == 3'd5))
      imm = {1'b0, alt, 4'b0, imm_in[5:0]};  // shamt form
    b = is_imm ? {{52{imm[11]}}, imm} : model[rs2];
    if (is_imm)
      prog.push_back({imm, 5'(rs1), f3, 5'(rd), OPC_IMM});
    else
      prog.push_back({1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP});
    set_reg(rd, alu_ref(f3, alt, model[rs1], b));
  endtask

  task automatic emit_upper(input logic auipc, input int rd, input logic [19:0] imm20);
    logic [63:0] pc;
    pc = ENTRY + 64'(prog.size()) * 4;
    prog.push_back({imm20, 5'(rd), auipc ? OPC_AUIPC : OPC_LUI});
    set_reg(rd, auipc ? pc + upper_imm(imm20) : upper_imm(imm20));
  endtask

  // 41 instructions over three lines that end in ecall
  task automatic build_program();
    int rd;
    int rs1;
    for (int i = 0; i < 32; i++)
      model[i] = '0;
    for (int k = 1; k <= 8; k++) begin  // seed x1..x8
      if (k % 2)
        emit_upper(1'b0, k, 20'($urandom));
      else
        emit_alu(1'b1, 3'd0, 1'b0, k, k - 1, 0, 12'($urandom));
    end
    for (int n = 0; n < 26; n++) begin
      rd  = (n == 0) ? 0 : $urandom_range(0, 15);  // first write targets x0
      rs1 = (n == 1) ? 0 : $urandom_range(0, 15);  // then x0 is read back
      emit_alu(1'($urandom), 3'($urandom), 1'($urandom), rd, rs1,
               $urandom_range(0, 15), 12'($urandom));
    end
    emit_alu(1'b0, 3'd0, 1'b0, 10, 10, 0, '0);                // a0 += x0 which must read zero
    emit_upper(1'b1, 20, 20'($urandom));                      // auipc x20
    emit_alu(1'b0, 3'd0, 1'b0, 10, 10, 20, '0);               // a0 += x20
    emit_alu(1'b0, 3'd4, 1'b0, 10, 10, $urandom_range(1, 9), '0);
    emit_upper(1'b0, 17, 20'($urandom));                      // a7 from lui
    emit_alu(1'b1, 3'd0, 1'b0, 17, 17, 0, 12'($urandom));     // plus addi
    prog.push_back(32'h0000_0073);                            // ecall
  endtask

  initial begin
    void'($urandom(2375));
    reset     = 1'b1;
    entry     = ENTRY;
    tb_errors = 0;
    @(posedge clk);
    build_program();
    foreach (prog[i])
      mem_i.store_instr(ENTRY + 64'(i) * 4, prog[i]);
    repeat (9) @(posedge clk);
    #1 reset = 1'b0;

    cycles = 0;
    while (!halted && cycles < TIMEOUT) begin
      @(posedge clk);
      #1 cycles++;
    end

    if (!halted) begin
      tb_errors++;
      $display("timeout: the core did not halt within %0d cycles", TIMEOUT);
    end else begin
      repeat (20) @(posedge clk);  // halt must hold with no new fetch
      #1;
      assert (exit_code == model[10]) else begin
        tb_errors++;
        $display("Fail exit_code: expected %h actual %h", model[10], exit_code);
      end
      assert (syscall_num == model[17]) else begin
        tb_errors++;
        $display("Fail syscall_num: expected %h actual %h", model[17], syscall_num);
      end
      assert (req_count == 3) else begin
        tb_errors++;
        $display("Fail line_requests: expected %0d actual %0d", 3, req_count);
      end
    end

    $display("errors: %0d testbench checks, %0d assertions", tb_errors,
             dut_i.chk_i.fail_count);
    if (tb_errors == 0 && dut_i.chk_i.fail_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/bus_fetch.sv
hdl/icache.sv
hdl/reg_decode.sv
hdl/alu.sv
hdl/writeback.sv
hdl/cpu_top.sv
testbench/sysbus_mem.sv
testbench/cpu_chk.sv
testbench/cpu_tb.sv
